// ==== Makefile ====
SRCS := vlog.f $(wildcard common/*.sv common/*.svh idiv/*.sv hw/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/tb_mant_div
	./obj_dir/tb_mant_div | tee sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/tb_mant_div: $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_mant_div -f vlog.f -o tb_mant_div

clean:
	rm -rf obj_dir sim.log

// ==== common/fdiv_config.svh ====
`ifndef FDIV_CONFIG_SVH
`define FDIV_CONFIG_SVH

// mantissa and quotient widths
`define FDIV_MANT_W 53
`define FDIV_QUOT_W 64
`define FDIV_EXT_W  11  // zero bits appended to the dividend

`define FDIV_ITERS  8   // 8 quotient bits per iteration
`define FDIV_IDX_W  7   // holds a bit position 0..63

`endif

// ==== common/fdiv_pkg.sv ====
`default_nettype none

`include "fdiv_config.svh"

package fdiv_pkg;

    // iterator state
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } div_state_e;

    typedef struct packed {
        logic [`FDIV_MANT_W-1:0] dividend;
        logic [`FDIV_MANT_W-1:0] divisor;   // bit 52 must be set
    } div_req_t;

    // unnormalized result from the iterator
    typedef struct packed {
        logic [`FDIV_QUOT_W-1:0] quot;
        logic [`FDIV_MANT_W-1:0] rem;
        logic [`FDIV_IDX_W-1:0]  lead_idx;     // position of first one in quot
        logic                    lead_found;
    } div_raw_t;

    typedef struct packed {
        logic [`FDIV_QUOT_W-1:0] quot;         // raw quotient
        logic [`FDIV_MANT_W-1:0] rem;
        logic [`FDIV_IDX_W-1:0]  norm_shift;   // 63 - lead index
        logic                    zero;
    } div_res_t;

endpackage

`default_nettype wire

// ==== hw/mant_div_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdiv_config.svh"

module mant_div_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    input  fdiv_pkg::div_req_t      i_req,
    output logic                    o_busy,
    output logic                    o_valid,
    output fdiv_pkg::div_res_t      o_res,
    output logic [`FDIV_QUOT_W-1:0] o_quot_norm
);

    fdiv_pkg::div_raw_t w_raw;
    logic               w_raw_valid;   // one cycle before o_valid

    idiv_iter u_iter (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_req       (i_req),
        .o_busy      (o_busy),
        .o_raw_valid (w_raw_valid),
        .o_raw       (w_raw)
    );

    quot_norm u_norm (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_raw_valid (w_raw_valid),
        .i_raw       (w_raw),
        .o_valid     (o_valid),
        .o_res       (o_res),
        .o_quot_norm (o_quot_norm)
    );

endmodule

`default_nettype wire

// ==== hw/quot_norm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdiv_config.svh"

// left-justifies the quotient using the lead index from the iterator
module quot_norm (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_raw_valid,
    input  fdiv_pkg::div_raw_t i_raw,
    output logic               o_valid,
    output fdiv_pkg::div_res_t o_res,
    output logic [`FDIV_QUOT_W-1:0] o_quot_norm
);

    logic [`FDIV_IDX_W-1:0] w_shift;

    assign w_shift = `FDIV_IDX_W'(`FDIV_QUOT_W - 1) - i_raw.lead_idx;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_raw_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_raw_valid) begin
            o_res.quot <= i_raw.quot;
            o_res.rem  <= i_raw.rem;
            o_res.zero <= !i_raw.lead_found;
            if (i_raw.lead_found) begin
                o_res.norm_shift <= w_shift;
                o_quot_norm      <= i_raw.quot << w_shift;
            end else begin
                o_res.norm_shift <= '0;  // zero quotient
                o_quot_norm      <= '0;
            end
        end
    end

    // lead index from the stage must point at the actual leading one
    a_norm_msb: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_valid && !o_res.zero) |-> o_quot_norm[`FDIV_QUOT_W-1])
        else $error("normalized quotient msb not set");

endmodule

`default_nettype wire

// ==== idiv/div_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdiv_config.svh"

// one radix-4 pass over a byte of the numerator, 4 digits of 2 bits each
module div_stage (
    input  logic                         i_mux_ena,    // still hunting for the lead bit
    input  logic [8*`FDIV_IDX_W-1:0]     i_muxind,     // 8 bit positions, msb field first
    input  logic [`FDIV_MANT_W+7:0]      i_dividend,   // residual then next byte
    input  logic [`FDIV_MANT_W-1:0]      i_divisor,
    output logic [`FDIV_MANT_W-1:0]      o_dif,        // new residual
    output logic [7:0]                   o_bits,
    output logic [`FDIV_IDX_W-1:0]       o_muxind,
    output logic                         o_muxind_rdy
);

    always_comb begin
        logic [`FDIV_MANT_W+1:0] divx2;
        logic [`FDIV_MANT_W+1:0] divx3;
        logic [`FDIV_MANT_W+8:0] sub3;
        logic [`FDIV_MANT_W+8:0] sub2;
        logic [`FDIV_MANT_W+8:0] sub1;
        logic [`FDIV_MANT_W+7:0] cur;
        logic [1:0]              dig;
        logic                    found;

        divx2 = {1'b0, i_divisor, 1'b0};
        divx3 = divx2 + {2'b0, i_divisor};

        cur      = i_dividend;
        o_bits   = '0;
        o_muxind = '0;
        found    = 1'b0;

        // substep s works at weight 4^(3-s)
        for (int s = 0; s < 4; s++) begin
            sub3 = {1'b0, cur} - ({7'b0, divx3} << (6 - 2 * s));
            sub2 = {1'b0, cur} - ({7'b0, divx2} << (6 - 2 * s));
            sub1 = {1'b0, cur} - ({9'b0, i_divisor} << (6 - 2 * s));

            // msb set means the subtraction went negative
            if (!sub3[`FDIV_MANT_W+8]) begin
                dig = 2'd3;
                cur = sub3[`FDIV_MANT_W+7:0];
            end else if (!sub2[`FDIV_MANT_W+8]) begin
                dig = 2'd2;
                cur = sub2[`FDIV_MANT_W+7:0];
            end else if (!sub1[`FDIV_MANT_W+8]) begin
                dig = 2'd1;
                cur = sub1[`FDIV_MANT_W+7:0];
            end else begin
                dig = 2'd0;  // residual unchanged
            end
            o_bits[7 - 2 * s -: 2] = dig;

            // digit 3 or 2 puts the lead one in the upper bit of the pair
            if (i_mux_ena && !found && (dig != 2'd0)) begin
                found = 1'b1;
                if (dig[1]) begin
                    o_muxind = i_muxind[8*`FDIV_IDX_W-1 - 2*`FDIV_IDX_W*s -: `FDIV_IDX_W];
                end else begin
                    o_muxind = i_muxind[7*`FDIV_IDX_W-1 - 2*`FDIV_IDX_W*s -: `FDIV_IDX_W];
                end
            end
        end

        o_dif        = cur[`FDIV_MANT_W-1:0];
        o_muxind_rdy = i_mux_ena && (|o_bits);
    end

    // a normalized divisor and an in-range residual keep the new residual below B
    always_comb begin
        if (i_divisor[`FDIV_MANT_W-1] && (i_dividend[`FDIV_MANT_W+7:8] < i_divisor)) begin
            a_dif_below_div: assert final (o_dif < i_divisor)
                else $error("div_stage residual not below divisor");
        end
    end

endmodule

`default_nettype wire

// ==== idiv/idiv_iter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdiv_config.svh"

// runs div_stage 8 times, one numerator byte per clock
module idiv_iter (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_start,
    input  fdiv_pkg::div_req_t i_req,
    output logic               o_busy,
    output logic               o_raw_valid,
    output fdiv_pkg::div_raw_t o_raw
);

    fdiv_pkg::div_state_e    r_state;
    logic [2:0]              r_cnt;        // byte being processed
    fdiv_pkg::div_req_t      r_req;
    logic [`FDIV_MANT_W-1:0] r_rem;
    logic [`FDIV_QUOT_W-1:0] r_quot;
    logic [`FDIV_IDX_W-1:0]  r_lead_idx;
    logic                    r_lead_found;
    logic                    r_raw_valid;

    logic                    w_accept;
    logic                    w_run;
    logic [`FDIV_QUOT_W-1:0] w_numer;
    logic [7:0]              w_byte;
    logic [8*`FDIV_IDX_W-1:0] w_muxind;
    logic                    w_mux_ena;
    logic [`FDIV_MANT_W-1:0] w_dif;
    logic [7:0]              w_bits;
    logic [`FDIV_IDX_W-1:0]  w_lead;
    logic                    w_lead_rdy;

    assign w_accept  = (r_state == fdiv_pkg::ST_IDLE) && i_start;
    assign w_run     = (r_state == fdiv_pkg::ST_RUN);
    assign w_mux_ena = w_run && !r_lead_found;  // stop looking once latched

    assign w_numer = {r_req.dividend, {`FDIV_EXT_W{1'b0}}};
    assign w_byte  = w_numer[`FDIV_QUOT_W - 1 - 8 * r_cnt -: 8];  // msb byte first

    // quotient positions of the 8 bits produced this pass
    always_comb begin
        for (int j = 0; j < 8; j++) begin
            w_muxind[8*`FDIV_IDX_W-1 - `FDIV_IDX_W*j -: `FDIV_IDX_W] =
                `FDIV_IDX_W'(`FDIV_QUOT_W - 1 - 8 * r_cnt - j);
        end
    end

    div_stage u_stage (
        .i_mux_ena    (w_mux_ena),
        .i_muxind     (w_muxind),
        .i_dividend   ({r_rem, w_byte}),
        .i_divisor    (r_req.divisor),
        .o_dif        (w_dif),
        .o_bits       (w_bits),
        .o_muxind     (w_lead),
        .o_muxind_rdy (w_lead_rdy)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state      <= fdiv_pkg::ST_IDLE;
            r_cnt        <= '0;
            r_lead_found <= 1'b0;
            r_raw_valid  <= 1'b0;
        end else begin
            r_raw_valid <= 1'b0;
            case (r_state)
                fdiv_pkg::ST_IDLE: begin
                    if (i_start) begin
                        r_state      <= fdiv_pkg::ST_RUN;
                        r_cnt        <= '0;
                        r_lead_found <= 1'b0;
                    end
                end
                fdiv_pkg::ST_RUN: begin
                    r_cnt <= r_cnt + 3'd1;
                    if (w_lead_rdy) begin
                        r_lead_found <= 1'b1;
                    end
                    if (r_cnt == 3'(`FDIV_ITERS - 1)) begin
                        r_state     <= fdiv_pkg::ST_DONE;
                        r_raw_valid <= 1'b1;
                    end
                end
                fdiv_pkg::ST_DONE: begin
                    // extra cycle covers the normalizer output slot
                    if (!r_raw_valid) begin
                        r_state <= fdiv_pkg::ST_IDLE;
                    end
                end
                default: r_state <= fdiv_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_req  <= i_req;
            r_rem  <= '0;
            r_quot <= '0;
        end else if (w_run) begin
            r_rem  <= w_dif;
            r_quot <= {r_quot[`FDIV_QUOT_W-9:0], w_bits};
        end
        if (w_lead_rdy) begin
            r_lead_idx <= w_lead;  // only first ready gets here
        end
    end

    assign o_busy      = w_run || r_raw_valid;
    assign o_raw_valid = r_raw_valid;

    assign o_raw.quot       = r_quot;
    assign o_raw.rem        = r_rem;
    assign o_raw.lead_idx   = r_lead_idx;
    assign o_raw.lead_found = r_lead_found;

    a_start_norm: assert property (@(posedge i_clk) disable iff (i_rst)
        w_accept |-> i_req.divisor[`FDIV_MANT_W-1])
        else $error("start with unnormalized divisor");

    a_raw_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_raw_valid |=> !o_raw_valid)
        else $error("o_raw_valid high two cycles in a row");

endmodule

`default_nettype wire

// ==== tb/tb_mant_div.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdiv_config.svh"

module tb_mant_div;

    localparam int MAX_CYCLES = 400 * 12 + 100;  // 400 ops at 12 cycles, plus margin

    logic                    i_clk;
    logic                    i_rst;
    logic                    i_start;
    fdiv_pkg::div_req_t      i_req;
    logic                    o_busy;
    logic                    o_valid;
    fdiv_pkg::div_res_t      o_res;
    logic [`FDIV_QUOT_W-1:0] o_quot_norm;

    integer seed;
    int     cycle_cnt = 0;
    int     ops_started = 0;
    int     valid_cnt = 0;

    mant_div_top u_mant_div_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_req       (i_req),
        .o_busy      (o_busy),
        .o_valid     (o_valid),
        .o_res       (o_res),
        .o_quot_norm (o_quot_norm)
    );

    always #20 i_clk = ~i_clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_on_error("timeout: the run exceeded its cycle limit");
        end
    end

    // every o_valid pulse over the whole run
    always @(negedge i_clk) begin
        if (o_valid) begin
            valid_cnt <= valid_cnt + 1;
        end
    end

    function automatic logic [63:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // reference divide of {A, 11 zeros} by B
    task automatic compute_model(
        input  logic [`FDIV_MANT_W-1:0]  a,
        input  logic [`FDIV_MANT_W-1:0]  b,
        output fdiv_pkg::div_res_t       res,
        output logic [`FDIV_QUOT_W-1:0]  norm
    );
        logic [`FDIV_QUOT_W-1:0] numer;
        logic [`FDIV_QUOT_W-1:0] quot;
        logic [`FDIV_QUOT_W-1:0] rem;
        int                      lead;

        numer = {a, {`FDIV_EXT_W{1'b0}}};
        quot  = numer / {{`FDIV_EXT_W{1'b0}}, b};
        rem   = numer % {{`FDIV_EXT_W{1'b0}}, b};
        lead  = -1;
        for (int i = 0; i < `FDIV_QUOT_W; i++) begin
            if (quot[i]) begin
                lead = i;  // last hit is the highest one
            end
        end
        res.quot = quot;
        res.rem  = rem[`FDIV_MANT_W-1:0];
        if (lead < 0) begin
            res.norm_shift = '0;
            res.zero       = 1'b1;
            norm           = '0;
        end else begin
            res.norm_shift = `FDIV_IDX_W'(`FDIV_QUOT_W - 1 - lead);
            res.zero       = 1'b0;
            norm           = quot << (`FDIV_QUOT_W - 1 - lead);
        end
    endtask

    task automatic check_val(
        input string       test,
        input string       field,
        input logic [63:0] exp_v,
        input logic [63:0] act_v
    );
        assert (act_v === exp_v)
            else stop_on_error($sformatf("error: %s %s expected %h actual %h",
                                         test, field, exp_v, act_v));
    endtask

    // one operation; inject adds ignored starts while busy and in the valid cycle
    task automatic run_op(
        input string                   test,
        input logic [`FDIV_MANT_W-1:0] a,
        input logic [`FDIV_MANT_W-1:0] b,
        input logic                    inject
    );
        fdiv_pkg::div_res_t      exp_res;
        logic [`FDIV_QUOT_W-1:0] exp_norm;
        fdiv_pkg::div_req_t      req;
        fdiv_pkg::div_req_t      alt;
        logic [63:0]             rnd;
        int                      n;

        compute_model(a, b, exp_res, exp_norm);
        if (!exp_res.zero) begin
            assert (exp_norm[`FDIV_QUOT_W-1])
                else stop_on_error("model normalized quotient has bit 63 clear");
        end
        rnd          = rand64();
        req.dividend = a;
        req.divisor  = b;
        alt.dividend = ~a;
        alt.divisor  = {1'b1, rnd[`FDIV_MANT_W-2:0]};

        @(posedge i_clk);
        i_start <= 1'b1;
        i_req   <= req;
        @(posedge i_clk);  // start sampled here
        i_start <= 1'b0;
        ops_started = ops_started + 1;
        n = 0;
        @(negedge i_clk);
        while (!o_valid && n < 20) begin
            assert (o_busy)
                else stop_on_error($sformatf("o_busy dropped %0d cycles after start in %s",
                                             n, test));
            @(posedge i_clk);
            n = n + 1;
            if (inject && (n == 3 || n == 9)) begin
                i_start <= 1'b1;
                i_req   <= alt;
            end else begin
                i_start <= 1'b0;
            end
            @(negedge i_clk);
        end
        check_val(test, "latency", 64'd9, 64'(n));
        assert (!o_busy)
            else stop_on_error($sformatf("o_busy still high in the o_valid cycle in %s", test));
        check_val(test, "quot", exp_res.quot, o_res.quot);
        check_val(test, "rem", 64'(exp_res.rem), 64'(o_res.rem));
        check_val(test, "norm_shift", 64'(exp_res.norm_shift), 64'(o_res.norm_shift));
        check_val(test, "zero", 64'(exp_res.zero), 64'(o_res.zero));
        check_val(test, "quot_norm", exp_norm, o_quot_norm);
    endtask

    task automatic idle_check(input string test, input int cycles);
        repeat (cycles) begin
            @(posedge i_clk);
            i_start <= 1'b0;
            @(negedge i_clk);
            assert (!o_valid)
                else stop_on_error($sformatf("extra o_valid after the operation in %s", test));
            assert (!o_busy)
                else stop_on_error($sformatf("o_busy high while idle in %s", test));
        end
    endtask

    initial begin
        logic [63:0]             rnd;
        logic [`FDIV_MANT_W-1:0] a;
        logic [`FDIV_MANT_W-1:0] b;
        int                      ge_cnt;
        int                      lt_cnt;

        seed    = 32'h447a;
        ge_cnt  = 0;
        lt_cnt  = 0;
        i_clk   = 1'b0;
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_req   = '0;

        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        assert (!o_busy && !o_valid)
            else stop_on_error("o_busy or o_valid high right after reset");

        // corner operands
        rnd = rand64();
        run_op("zero_a", '0, {1'b1, rnd[`FDIV_MANT_W-2:0]}, 1'b0);
        run_op("zero_a_min_b", '0, {1'b1, {(`FDIV_MANT_W-1){1'b0}}}, 1'b0);
        rnd = rand64();
        b = {1'b1, rnd[`FDIV_MANT_W-2:0]};
        run_op("a_eq_b", b, b, 1'b0);
        run_op("max_quot", '1, {1'b1, {(`FDIV_MANT_W-1){1'b0}}}, 1'b0);
        run_op("min_quot_max_b", {1'b1, {(`FDIV_MANT_W-1){1'b0}}}, '1, 1'b0);

        // walk the leading one down through the low quotient bytes
        for (int k = 41; k <= `FDIV_MANT_W; k++) begin
            rnd = rand64();
            a = rnd[`FDIV_MANT_W-1:0] >> (`FDIV_MANT_W - k);
            a[k-1] = 1'b1;
            rnd = rand64();
            run_op("lead_sweep", a, {1'b1, rnd[`FDIV_MANT_W-2:0]}, 1'b0);
        end

        // each run_op starts in the cycle after the previous o_valid
        for (int i = 0; i < 300; i++) begin
            rnd = rand64();
            a = rnd[`FDIV_MANT_W-1:0];
            rnd = rand64();
            b = {1'b1, rnd[`FDIV_MANT_W-2:0]};
            if (a >= b) begin
                ge_cnt = ge_cnt + 1;
            end else begin
                lt_cnt = lt_cnt + 1;
            end
            run_op("random", a, b, 1'b0);
        end
        assert (ge_cnt > 0 && lt_cnt > 0)
            else stop_on_error("random operands did not cover both A below B and A above B");

        // starts while busy must be dropped
        for (int i = 0; i < 4; i++) begin
            rnd = rand64();
            a = rnd[`FDIV_MANT_W-1:0];
            rnd = rand64();
            run_op("busy_ignore", a, {1'b1, rnd[`FDIV_MANT_W-2:0]}, 1'b1);
            idle_check("busy_ignore", 12);
        end

        if (valid_cnt == ops_started) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("error: end_of_run valid_count expected %0d actual %0d",
                                    ops_started, valid_cnt));
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/fdiv_pkg.sv
idiv/div_stage.sv
idiv/idiv_iter.sv
hw/quot_norm.sv
hw/mant_div_top.sv
tb/tb_mant_div.sv
